// ==== hw/visPkg.sv ====
package visPkg;

	// audio sample, band output and monitor output
	typedef logic signed [15:0] sampleT;
	// band power, always non-negative
	typedef logic [15:0] powerT;
	// scan coordinates
	typedef logic [9:0] pixXT;
	typedef logic [8:0] pixYT;
	// one colour channel
	typedef logic [7:0] colorT;

	localparam int NUM_BANDS = 4;
	localparam int BAR_SEGS = 4;
	// layer index is band * BAR_SEGS + segment
	localparam int NUM_LAYERS = NUM_BANDS * BAR_SEGS;

	// filter state precision
	localparam int ACC_W = 20;
	// leak of the power meter
	localparam int POW_SHIFT = 3;

	// bar geometry in pixels
	localparam int BAR_X0 = 40;
	localparam int BAR_PITCH = 120;
	localparam int BAR_W = 80;
	// segment 0 sits at the bottom of the bar
	localparam int SEG_Y0 = 40;
	localparam int SEG_PITCH = 100;
	localparam int SEG_H = 80;

	// power needed to light each segment, bottom to top
	localparam powerT SEG_THRESH [BAR_SEGS] = '{16'd64, 16'd512, 16'd2048, 16'd8192};

	// green, yellow-green, orange, red
	localparam colorT SEG_RED [BAR_SEGS] = '{8'd0, 8'd160, 8'd255, 8'd255};
	localparam colorT SEG_GREEN [BAR_SEGS] = '{8'd255, 8'd255, 8'd140, 8'd0};
	localparam colorT SEG_BLUE [BAR_SEGS] = '{8'd0, 8'd0, 8'd0, 8'd0};

endpackage

// ==== hw/layerIf.sv ====
`timescale 1ns/1ps

// per-layer hit flags and colours, bar field to mixer
interface layerIf;

	// one flag per segment of every bar
	logic [visPkg::NUM_LAYERS-1:0] lit;
	visPkg::colorT red [visPkg::NUM_LAYERS];
	visPkg::colorT green [visPkg::NUM_LAYERS];
	visPkg::colorT blue [visPkg::NUM_LAYERS];

	// bar field side
	modport src (output lit, red, green, blue);
	// mixer side
	modport dst (input lit, red, green, blue);

endinterface

// ==== hw/bandFilter.sv ====
`timescale 1ns/1ps

module bandFilter #(
	parameter int bandIdx = 0
) (
	input logic clk,
	input logic rst,
	input logic audStrobe,
	input visPkg::sampleT audIn,
	output visPkg::sampleT band,
	output visPkg::powerT power
);

	// two one-pole low-pass states
	logic signed [visPkg::ACC_W-1:0] fastQ;
	logic signed [visPkg::ACC_W-1:0] slowQ;
	logic signed [visPkg::ACC_W-1:0] sampleExt;
	logic signed [visPkg::ACC_W-1:0] fastDiff;
	logic signed [visPkg::ACC_W-1:0] slowDiff;
	logic signed [visPkg::ACC_W-1:0] fastNext;
	logic signed [visPkg::ACC_W-1:0] slowNext;
	logic signed [visPkg::ACC_W-1:0] bandWide;
	visPkg::sampleT bandSat;
	// magnitude needs one more bit for -32768
	logic [16:0] bandMag;
	logic signed [17:0] powDiff;
	logic signed [17:0] powNext;

	// sign extend sample into filter precision
	assign sampleExt = {{(visPkg::ACC_W - 16){audIn[15]}}, audIn};

	// higher bands get slower corners on both poles
	assign fastDiff = sampleExt - fastQ;
	assign slowDiff = sampleExt - slowQ;
	assign fastNext = fastQ + (fastDiff >>> (1 + bandIdx));
	assign slowNext = slowQ + (slowDiff >>> (3 + bandIdx));

	// band pass as difference of the two low passes
	assign bandWide = fastNext - slowNext;

	always_comb begin
		if (bandWide > 32767) begin
			bandSat = 16'sh7fff;
		end else if (bandWide < -32768) begin
			bandSat = 16'sh8000;
		end else begin
			bandSat = bandWide[15:0];
		end
	end

	// rectify
	assign bandMag = bandSat[15] ? 17'(-{bandSat[15], bandSat}) : {1'b0, bandSat};

	// leaky meter follows the magnitude
	assign powDiff = $signed({1'b0, bandMag}) - $signed({2'b00, power});
	assign powNext = $signed({2'b00, power}) + (powDiff >>> visPkg::POW_SHIFT);

	always_ff @(posedge clk) begin
		if (rst) begin
			fastQ <= '0;
			slowQ <= '0;
			band <= '0;
			power <= '0;
		end else if (audStrobe) begin
			fastQ <= fastNext;
			slowQ <= slowNext;
			band <= bandSat;
			power <= powNext[15:0];
		end
	end

	// leak step is floored, so power stays below the magnitude ceiling
	assert property (@(posedge clk) disable iff (rst) power <= 16'd32767);

endmodule

// ==== hw/bandBank.sv ====
`timescale 1ns/1ps

module bandBank (
	input logic clk,
	input logic rst,
	input logic audStrobe,
	input visPkg::sampleT audIn,
	input logic [visPkg::NUM_BANDS-1:0] bandEn,
	output visPkg::sampleT audOut,
	output visPkg::powerT power [visPkg::NUM_BANDS]
);

	visPkg::sampleT bandOut [visPkg::NUM_BANDS];
	// headroom for the full sum
	logic signed [17:0] sumWide;

	// one filter per band, corner set by index
	for (genvar b = 0; b < visPkg::NUM_BANDS; b++) begin : genBand
		bandFilter #(
			.bandIdx(b)
		) uFilter (
			.clk(clk),
			.rst(rst),
			.audStrobe(audStrobe),
			.audIn(audIn),
			.band(bandOut[b]),
			.power(power[b])
		);
	end

	// each band scaled by a quarter before mixing
	always_comb begin
		sumWide = '0;
		for (int b = 0; b < visPkg::NUM_BANDS; b++) begin
			if (bandEn[b]) begin
				sumWide = sumWide + 18'(bandOut[b] >>> 2);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			audOut <= '0;
		end else begin
			audOut <= sumWide[15:0];
		end
	end

	// muted bank gives silence on the next cycle
	assert property (@(posedge clk) disable iff (rst) ($past(bandEn) == '0) |-> (audOut == '0));

endmodule

// ==== hw/levelBar.sv ====
`timescale 1ns/1ps

module levelBar #(
	parameter int barIdx = 0
) (
	input logic clk,
	input logic rst,
	input visPkg::pixXT pixX,
	input visPkg::pixYT pixY,
	input visPkg::powerT power,
	output logic [visPkg::BAR_SEGS-1:0] lit,
	output visPkg::colorT red [visPkg::BAR_SEGS],
	output visPkg::colorT green [visPkg::BAR_SEGS],
	output visPkg::colorT blue [visPkg::BAR_SEGS]
);

	logic inX;
	logic [visPkg::BAR_SEGS-1:0] inY;
	logic [visPkg::BAR_SEGS-1:0] segOn;

	// same column span for every segment of this bar
	assign inX = (pixX >= visPkg::BAR_X0 + barIdx * visPkg::BAR_PITCH)
		&& (pixX < visPkg::BAR_X0 + barIdx * visPkg::BAR_PITCH + visPkg::BAR_W);

	always_comb begin
		for (int s = 0; s < visPkg::BAR_SEGS; s++) begin
			// segment 0 is the lowest row
			inY[s] = (pixY >= visPkg::SEG_Y0 + (visPkg::BAR_SEGS - 1 - s) * visPkg::SEG_PITCH)
				&& (pixY < visPkg::SEG_Y0 + (visPkg::BAR_SEGS - 1 - s) * visPkg::SEG_PITCH
				+ visPkg::SEG_H);
			// hit and loud enough
			segOn[s] = inX && inY[s] && (power >= visPkg::SEG_THRESH[s]);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			lit <= '0;
		end else begin
			lit <= segOn;
		end
	end

	// colour payload, black when the segment is dark
	always_ff @(posedge clk) begin
		for (int s = 0; s < visPkg::BAR_SEGS; s++) begin
			red[s] <= segOn[s] ? visPkg::SEG_RED[s] : '0;
			green[s] <= segOn[s] ? visPkg::SEG_GREEN[s] : '0;
			blue[s] <= segOn[s] ? visPkg::SEG_BLUE[s] : '0;
		end
	end

endmodule

// ==== hw/barField.sv ====
`timescale 1ns/1ps

module barField (
	input logic clk,
	input logic rst,
	input visPkg::pixXT pixX,
	input visPkg::pixYT pixY,
	input visPkg::powerT power [visPkg::NUM_BANDS],
	layerIf.src layers
);

	// one bar per band, left to right
	for (genvar b = 0; b < visPkg::NUM_BANDS; b++) begin : genBar
		logic [visPkg::BAR_SEGS-1:0] barLit;
		visPkg::colorT barRed [visPkg::BAR_SEGS];
		visPkg::colorT barGreen [visPkg::BAR_SEGS];
		visPkg::colorT barBlue [visPkg::BAR_SEGS];

		levelBar #(
			.barIdx(b)
		) uBar (
			.clk(clk),
			.rst(rst),
			.pixX(pixX),
			.pixY(pixY),
			.power(power[b]),
			.lit(barLit),
			.red(barRed),
			.green(barGreen),
			.blue(barBlue)
		);

		// band-major layer numbering
		for (genvar s = 0; s < visPkg::BAR_SEGS; s++) begin : genSeg
			assign layers.lit[b * visPkg::BAR_SEGS + s] = barLit[s];
			assign layers.red[b * visPkg::BAR_SEGS + s] = barRed[s];
			assign layers.green[b * visPkg::BAR_SEGS + s] = barGreen[s];
			assign layers.blue[b * visPkg::BAR_SEGS + s] = barBlue[s];
		end
	end

endmodule

// ==== hw/layerMixer.sv ====
`timescale 1ns/1ps

module layerMixer (
	input logic clk,
	input logic rst,
	layerIf.dst layers,
	output visPkg::colorT red,
	output visPkg::colorT green,
	output visPkg::colorT blue
);

	logic anyLit;
	logic [$clog2(visPkg::NUM_LAYERS)-1:0] topIdx;

	// priority encode, later index overrides
	always_comb begin
		anyLit = 1'b0;
		topIdx = '0;
		for (int i = 0; i < visPkg::NUM_LAYERS; i++) begin
			if (layers.lit[i]) begin
				anyLit = 1'b1;
				topIdx = i[$clog2(visPkg::NUM_LAYERS)-1:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			red <= '0;
			green <= '0;
			blue <= '0;
		end else if (anyLit) begin
			red <= layers.red[topIdx];
			green <= layers.green[topIdx];
			blue <= layers.blue[topIdx];
		end else begin
			// background
			red <= '0;
			green <= '0;
			blue <= '0;
		end
	end

	// segment rectangles are disjoint across every bar
	assert property (@(posedge clk) disable iff (rst) $onehot0(layers.lit));

endmodule

// ==== hw/screenManager.sv ====
`timescale 1ns/1ps

module screenManager (
	input logic clk,
	input logic rst,
	input logic audStrobe,
	input visPkg::sampleT audIn,
	input logic [visPkg::NUM_BANDS-1:0] bandEn,
	input visPkg::pixXT pixX,
	input visPkg::pixYT pixY,
	output visPkg::sampleT audOut,
	output visPkg::colorT red,
	output visPkg::colorT green,
	output visPkg::colorT blue
);

	// band powers, audio side to video side
	visPkg::powerT power [visPkg::NUM_BANDS];

	// segment bundle
	layerIf layerBus ();

	// filters, meters and monitor mix
	bandBank uBank (
		.clk(clk),
		.rst(rst),
		.audStrobe(audStrobe),
		.audIn(audIn),
		.bandEn(bandEn),
		.audOut(audOut),
		.power(power)
	);

	// level bars against the scan position
	barField uField (
		.clk(clk),
		.rst(rst),
		.pixX(pixX),
		.pixY(pixY),
		.power(power),
		.layers(layerBus.src)
	);

	layerMixer uMixer (
		.clk(clk),
		.rst(rst),
		.layers(layerBus.dst),
		.red(red),
		.green(green),
		.blue(blue)
	);

endmodule

// ==== testbench/tbScreenManager.sv ====
`timescale 1ns/1ps

module tbScreenManager;

	logic clk;
	logic rst;
	logic audStrobe;
	visPkg::sampleT audIn;
	logic [visPkg::NUM_BANDS-1:0] bandEn;
	visPkg::pixXT pixX;
	visPkg::pixYT pixY;
	visPkg::sampleT audOut;
	visPkg::colorT red;
	visPkg::colorT green;
	visPkg::colorT blue;

	integer seed = 69;
	int errorCount = 0;
	int timeoutCount = 0;
	// checks start once reset has reached every register
	logic checkOn = 1'b0;

	// one sine period, eight samples
	localparam visPkg::sampleT sineTab [8] = '{16'sd0, 16'sd19799, 16'sd28000, 16'sd19799,
		16'sd0, -16'sd19799, -16'sd28000, -16'sd19799};

	// model state per band
	int fastM [visPkg::NUM_BANDS];
	int slowM [visPkg::NUM_BANDS];
	int bandM [visPkg::NUM_BANDS];
	int powM [visPkg::NUM_BANDS];
	visPkg::sampleT expAud;
	// expected {red, green, blue}, one and two cycles behind the pixel
	logic [23:0] expPix1;
	logic [23:0] expPix2;

	screenManager DUT (
		.clk(clk),
		.rst(rst),
		.audStrobe(audStrobe),
		.audIn(audIn),
		.bandEn(bandEn),
		.pixX(pixX),
		.pixY(pixY),
		.audOut(audOut),
		.red(red),
		.green(green),
		.blue(blue)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// layer under a pixel, -1 for background
	function automatic int layerAt(input int x, input int y);
		int dx;
		int dy;
		int row;
		dx = x - visPkg::BAR_X0;
		dy = y - visPkg::SEG_Y0;
		if (dx < 0 || dy < 0) return -1;
		// gap between bars, or right of the last one
		if (dx / visPkg::BAR_PITCH >= visPkg::NUM_BANDS) return -1;
		if (dx % visPkg::BAR_PITCH >= visPkg::BAR_W) return -1;
		row = dy / visPkg::SEG_PITCH;
		if (row >= visPkg::BAR_SEGS || dy % visPkg::SEG_PITCH >= visPkg::SEG_H) return -1;
		// rows count down from the top segment
		return (dx / visPkg::BAR_PITCH) * visPkg::BAR_SEGS + (visPkg::BAR_SEGS - 1 - row);
	endfunction

	// colour expected for a pixel at the current model powers
	function automatic logic [23:0] colourAt(input int x, input int y);
		int layer;
		int seg;
		layer = layerAt(x, y);
		if (layer < 0) return '0;
		seg = layer % visPkg::BAR_SEGS;
		if (powM[layer / visPkg::BAR_SEGS] < int'(visPkg::SEG_THRESH[seg])) return '0;
		return {visPkg::SEG_RED[seg], visPkg::SEG_GREEN[seg], visPkg::SEG_BLUE[seg]};
	endfunction

	// reference model, register for register with the audio and video paths
	always @(posedge clk) begin
		int fastN;
		int slowN;
		int bandN;
		int sum;
		if (rst) begin
			for (int b = 0; b < visPkg::NUM_BANDS; b++) begin
				fastM[b] <= 0;
				slowM[b] <= 0;
				bandM[b] <= 0;
				powM[b] <= 0;
			end
			expAud <= '0;
			expPix1 <= '0;
			expPix2 <= '0;
		end else begin
			// mix uses band values from before this edge
			sum = 0;
			for (int b = 0; b < visPkg::NUM_BANDS; b++) begin
				if (bandEn[b]) begin
					sum = sum + (bandM[b] >>> 2);
				end
			end
			expAud <= visPkg::sampleT'(sum);
			expPix1 <= colourAt(int'(pixX), int'(pixY));
			expPix2 <= expPix1;
			if (audStrobe) begin
				for (int b = 0; b < visPkg::NUM_BANDS; b++) begin
					fastN = fastM[b] + ((int'(audIn) - fastM[b]) >>> (1 + b));
					slowN = slowM[b] + ((int'(audIn) - slowM[b]) >>> (3 + b));
					bandN = fastN - slowN;
					if (bandN > 32767) begin
						bandN = 32767;
					end else if (bandN < -32768) begin
						bandN = -32768;
					end
					fastM[b] <= fastN;
					slowM[b] <= slowN;
					bandM[b] <= bandN;
					// leak toward the rectified band value
					powM[b] <= powM[b]
						+ (((bandN < 0) ? -bandN : bandN) - powM[b] >>> visPkg::POW_SHIFT);
				end
			end
		end
	end

	assert property (@(posedge clk) disable iff (!checkOn) audOut == expAud) else begin
		errorCount++;
		$display("CHECK FAILED audOut at %0t: got %h, expected %h",
			$time, $sampled(audOut), $sampled(expAud));
	end

	// full mute must give silence one cycle later
	assert property (@(posedge clk) disable iff (!checkOn || rst)
		($past(bandEn) == '0) |-> (audOut == '0)) else begin
		errorCount++;
		$display("CHECK FAILED audOut at %0t: got %h, expected %h after mute",
			$time, $sampled(audOut), 16'h0000);
	end

	assert property (@(posedge clk) disable iff (!checkOn) red == expPix2[23:16]) else begin
		errorCount++;
		$display("CHECK FAILED red at %0t: got %h, expected %h",
			$time, $sampled(red), $sampled(expPix2[23:16]));
	end

	assert property (@(posedge clk) disable iff (!checkOn) green == expPix2[15:8]) else begin
		errorCount++;
		$display("CHECK FAILED green at %0t: got %h, expected %h",
			$time, $sampled(green), $sampled(expPix2[15:8]));
	end

	assert property (@(posedge clk) disable iff (!checkOn) blue == expPix2[7:0]) else begin
		errorCount++;
		$display("CHECK FAILED blue at %0t: got %h, expected %h",
			$time, $sampled(blue), $sampled(expPix2[7:0]));
	end

	// one audio cycle, entered and left on a falling edge
	task automatic audioCycle(input logic strobe, input visPkg::sampleT sample);
		audStrobe = strobe;
		audIn = sample;
		@(negedge clk);
	endtask

	// one scan position, audio held still
	task automatic pixelCycle(input int x, input int y);
		audStrobe = 1'b0;
		pixX = visPkg::pixXT'(x);
		pixY = visPkg::pixYT'(y);
		@(negedge clk);
	endtask

	// corners, centre and one pixel past each edge of every segment
	task automatic sweepSegments();
		int x0;
		int y0;
		for (int b = 0; b < visPkg::NUM_BANDS; b++) begin
			for (int s = 0; s < visPkg::BAR_SEGS; s++) begin
				x0 = visPkg::BAR_X0 + b * visPkg::BAR_PITCH;
				y0 = visPkg::SEG_Y0 + (visPkg::BAR_SEGS - 1 - s) * visPkg::SEG_PITCH;
				pixelCycle(x0, y0);
				pixelCycle(x0 + visPkg::BAR_W - 1, y0 + visPkg::SEG_H - 1);
				pixelCycle(x0 + visPkg::BAR_W / 2, y0 + visPkg::SEG_H / 2);
				pixelCycle(x0 - 1, y0);
				pixelCycle(x0 + visPkg::BAR_W, y0);
				pixelCycle(x0, y0 - 1);
				pixelCycle(x0, y0 + visPkg::SEG_H);
			end
		end
	endtask

	// random pixels that miss every bar
	task automatic sweepOutside(input int count);
		int x;
		int y;
		int done;
		done = 0;
		while (done < count) begin
			x = {$random(seed)} % 1024;
			y = {$random(seed)} % 512;
			if (layerAt(x, y) < 0) begin
				pixelCycle(x, y);
				done++;
			end
		end
	endtask

	// silent samples until every model power is under the limit
	task automatic waitDecay(input int limit, input int maxCycles);
		int n;
		bit quiet;
		n = 0;
		quiet = 1'b0;
		while (!quiet && n < maxCycles) begin
			audioCycle(1'b1, '0);
			n++;
			quiet = 1'b1;
			for (int b = 0; b < visPkg::NUM_BANDS; b++) begin
				if (powM[b] >= limit) quiet = 1'b0;
			end
		end
		if (!quiet) begin
			timeoutCount++;
			$display("Timeout: band powers still at or above %0d after %0d silent samples",
				limit, maxCycles);
		end
	endtask

	initial begin
		rst = 1'b1;
		audStrobe = 1'b0;
		audIn = '0;
		bandEn = '1;
		pixX = '0;
		pixY = '0;
		// first edge loads the reset values, checking starts after it
		@(negedge clk);
		checkOn = 1'b1;
		repeat (15) @(negedge clk);
		rst = 1'b0;
		audioCycle(1'b0, '0);
		// random samples at random gaps, gap 0 is back to back
		repeat (300) begin
			repeat ({$random(seed)} % 4) audioCycle(1'b0, '0);
			audioCycle(1'b1, visPkg::sampleT'($random(seed)));
		end
		// random masks, three muted cycles in every ten
		for (int i = 0; i < 300; i++) begin
			bandEn = (i % 10 < 3) ? '0 : visPkg::NUM_BANDS'($random(seed));
			audioCycle(({$random(seed)} % 3) != 0, visPkg::sampleT'($random(seed)));
		end
		bandEn = '1;
		// loud tone to raise the meters
		for (int i = 0; i < 480; i++) begin
			audioCycle(1'b1, sineTab[i % 8]);
		end
		sweepOutside(200);
		sweepSegments();
		// partial decay, lower segments only
		waitDecay(int'(visPkg::SEG_THRESH[2]), 5000);
		sweepSegments();
		waitDecay(int'(visPkg::SEG_THRESH[0]), 20000);
		sweepSegments();
		// drain the pixel pipeline
		repeat (4) @(negedge clk);
		$display("errors: %0d, timeouts: %0d", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== project.f ====
hw/visPkg.sv
hw/layerIf.sv
hw/bandFilter.sv
hw/bandBank.sv
hw/levelBar.sv
hw/barField.sv
hw/layerMixer.sv
hw/screenManager.sv
testbench/tbScreenManager.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tbScreenManager
out=$(./obj_dir/VtbScreenManager)
echo "$out"
# pass only when the testbench printed its pass line
echo "$out" | grep -q "Simulation finished: PASS"
